// File: logic/ps2_pkg.sv
package ps2_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Frame layout
	////////////////////////////////////////////////////////////////////////////

	// Data bits per frame, sent LSB first
	localparam int data_bits = 8;

	// Line level of the start bit and of the stop bit
	localparam logic start_level = 1'b0;
	localparam logic stop_level  = 1'b1;

	// One received byte
	typedef logic [data_bits-1:0] ps2_byte_t;

	// Error codes reported with rx_error
	typedef enum logic [1:0] {
		// Nothing wrong
		err_none    = 2'd0,
		// Data plus parity not odd
		err_parity  = 2'd1,
		// Stop bit seen as 0
		err_frame   = 2'd2,
		// Device stopped clocking mid frame
		err_timeout = 2'd3
	} ps2_err_t;

endpackage

// File: logic/ps2_line_sync.sv
`timescale 1ns/1ps

module ps2_line_sync #(
	parameter int sync_stages = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic ps2_clk,
	input  logic ps2_data,
	output logic fall_strobe,
	output logic data_bit
);

	// Synchronizer chains, stage 0 samples the pin
	logic [sync_stages-1:0] clk_sync;
	logic [sync_stages-1:0] data_sync;
	// Last synchronized ps2_clk sample, for edge detect
	logic clk_prev;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			// Lines idle high
			clk_sync    <= '1;
			data_sync   <= '1;
			clk_prev    <= 1'b1;
			fall_strobe <= 1'b0;
			data_bit    <= 1'b1;
		end else begin
			clk_sync[0]  <= ps2_clk;
			data_sync[0] <= ps2_data;
			for (int i = 1; i < sync_stages; i++) begin
				clk_sync[i]  <= clk_sync[i-1];
				data_sync[i] <= data_sync[i-1];
			end
			clk_prev <= clk_sync[sync_stages-1];
			// High then low on the synced clock
			fall_strobe <= clk_prev & ~clk_sync[sync_stages-1];
			// Data registered alongside the strobe
			data_bit <= data_sync[sync_stages-1];
		end
	end

endmodule

// File: logic/ps2_bit_timer.sv
`timescale 1ns/1ps

module ps2_bit_timer #(
	parameter int timeout_cycles = 100000
) (
	input  logic clk,
	input  logic reset,
	input  logic frame_clear,
	input  logic shift_en,
	input  logic fall_strobe,
	input  logic timing_active,
	output logic last_data_bit,
	output logic timeout
);

	localparam int bit_cnt_w  = $clog2(ps2_pkg::data_bits + 1);
	localparam int idle_cnt_w = $clog2(timeout_cycles + 1);

	// Data bits shifted so far
	logic [bit_cnt_w-1:0]  bit_cnt;
	// clk cycles since the last ps2_clk falling edge
	logic [idle_cnt_w-1:0] idle_cnt;

	////////////////////////////////////////////////////////////////////////////
	// Bit counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			bit_cnt <= '0;
		end else if (frame_clear) begin
			bit_cnt <= '0;
		end else if (shift_en && !last_data_bit) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// Full byte shifted
	assign last_data_bit = (bit_cnt == bit_cnt_w'(ps2_pkg::data_bits));

	////////////////////////////////////////////////////////////////////////////
	// Idle counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			idle_cnt <= '0;
		end else if (frame_clear || fall_strobe) begin
			idle_cnt <= '0;
		end else if (timing_active && idle_cnt != idle_cnt_w'(timeout_cycles)) begin
			// Saturates so the pulse fires once
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	// Single cycle, timeout_cycles after the last strobe
	assign timeout = timing_active && !fall_strobe &&
		(idle_cnt == idle_cnt_w'(timeout_cycles - 1));

endmodule

// File: logic/ps2_rx_fsm.sv
`timescale 1ns/1ps

module ps2_rx_fsm (
	input  logic              clk,
	input  logic              reset,
	input  logic              rx_enable,
	input  logic              hold_data,
	input  logic              fall_strobe,
	input  logic              data_bit,
	input  logic              last_data_bit,
	input  logic              timeout,
	input  logic              parity_ok,
	output logic              frame_clear,
	output logic              shift_en,
	output logic              timing_active,
	output logic              load_byte,
	output logic              load_error,
	output ps2_pkg::ps2_err_t err_sel,
	output logic              rx_complete
);

	typedef enum logic [2:0] {
		idle,
		data,
		parity,
		stop,
		complete,
		error_flag
	} state_t;

	state_t state;
	state_t next_state;
	// Parity result taken at the parity strobe
	logic parity_good;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state       <= idle;
			parity_good <= 1'b0;
		end else begin
			state <= next_state;
			if (state == parity && fall_strobe) begin
				parity_good <= parity_ok;
			end
		end
	end

	// Frame in flight, stall watch on
	assign timing_active = (state == data) || (state == parity) || (state == stop);
	// Byte held for the consumer
	assign rx_complete = (state == complete);

	////////////////////////////////////////////////////////////////////////////
	// Next state and strobes
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state  = state;
		frame_clear = 1'b0;
		shift_en    = 1'b0;
		load_byte   = 1'b0;
		load_error  = 1'b0;
		err_sel     = ps2_pkg::err_none;
		case (state)
			idle: begin
				// Start bit only, a high strobe is noise
				if (rx_enable && fall_strobe && data_bit == ps2_pkg::start_level) begin
					frame_clear = 1'b1;
					next_state  = data;
				end
			end
			data: begin
				if (last_data_bit) begin
					next_state = parity;
				end else if (fall_strobe) begin
					shift_en = 1'b1;
				end
			end
			parity: begin
				if (fall_strobe) begin
					next_state = stop;
				end
			end
			stop: begin
				if (fall_strobe) begin
					if (!parity_good) begin
						load_error = 1'b1;
						err_sel    = ps2_pkg::err_parity;
						next_state = error_flag;
					end else if (data_bit != ps2_pkg::stop_level) begin
						load_error = 1'b1;
						err_sel    = ps2_pkg::err_frame;
						next_state = error_flag;
					end else begin
						load_byte  = 1'b1;
						next_state = complete;
					end
				end
			end
			// Strobes ignored here, frames dropped
			complete: begin
				if (!hold_data) begin
					next_state = idle;
				end
			end
			// One cycle, lines up with rx_error
			error_flag: next_state = idle;
			default: next_state = idle;
		endcase
		// Mid frame overrides
		if (timing_active) begin
			if (!rx_enable) begin
				// Abandoned quietly
				next_state = idle;
				shift_en   = 1'b0;
				load_byte  = 1'b0;
				load_error = 1'b0;
				err_sel    = ps2_pkg::err_none;
			end else if (timeout) begin
				load_error = 1'b1;
				err_sel    = ps2_pkg::err_timeout;
				next_state = error_flag;
			end
		end
	end

endmodule

// File: logic/ps2_frame_shift.sv
`timescale 1ns/1ps

module ps2_frame_shift (
	input  logic               clk,
	input  logic               reset,
	input  logic               frame_clear,
	input  logic               shift_en,
	input  logic               data_bit,
	output ps2_pkg::ps2_byte_t frame_byte,
	output logic               parity_ok
);

	// Byte being assembled
	ps2_pkg::ps2_byte_t shift_reg;
	// XOR of the data bits so far
	logic par_acc;

	// Data byte shift register
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			shift_reg <= '0;
		end else if (frame_clear) begin
			// Cleared at each start bit
			shift_reg <= '0;
		end else if (shift_en) begin
			// In at the MSB so the first bit lands in bit 0
			shift_reg <= {data_bit, shift_reg[ps2_pkg::data_bits-1:1]};
		end
	end

	// Running parity
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			par_acc <= 1'b0;
		end else if (frame_clear) begin
			par_acc <= 1'b0;
		end else if (shift_en) begin
			par_acc <= par_acc ^ data_bit;
		end
	end

	assign frame_byte = shift_reg;
	// Odd total wanted with data_bit as the parity bit
	assign parity_ok = par_acc ^ data_bit;

endmodule

// File: logic/ps2_code_hold.sv
`timescale 1ns/1ps

module ps2_code_hold (
	input  logic               clk,
	input  logic               reset,
	input  logic               load_byte,
	input  logic               load_error,
	input  ps2_pkg::ps2_byte_t frame_byte,
	input  ps2_pkg::ps2_err_t  err_sel,
	output ps2_pkg::ps2_byte_t rx_data,
	output logic               rx_error,
	output ps2_pkg::ps2_err_t  err_code
);

	// Last good byte, kept across bad frames
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rx_data <= '0;
		end else if (load_byte) begin
			rx_data <= frame_byte;
		end
	end

	// Error pulse and sticky code
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rx_error <= 1'b0;
			err_code <= ps2_pkg::err_none;
		end else begin
			rx_error <= load_error;
			// Code valid from the rx_error cycle on
			if (load_error) begin
				err_code <= err_sel;
			end
		end
	end

endmodule

// File: logic/ps2_rx_top.sv
`timescale 1ns/1ps

module ps2_rx_top #(
	// Idle clk cycles before a stalled frame is dropped, 2 ms at 50 MHz
	parameter int timeout_cycles = 100000,
	parameter int sync_stages    = 2
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               rx_enable,
	input  logic               ps2_clk,
	input  logic               ps2_data,
	input  logic               hold_data,
	output ps2_pkg::ps2_byte_t rx_data,
	output logic               rx_complete,
	output logic               rx_error,
	output ps2_pkg::ps2_err_t  err_code
);

	// Line sync outputs
	logic fall_strobe;
	logic data_bit;
	// FSM controls
	logic              frame_clear;
	logic              shift_en;
	logic              timing_active;
	logic              load_byte;
	logic              load_error;
	ps2_pkg::ps2_err_t err_sel;
	// Timer and shifter status
	logic               last_data_bit;
	logic               timeout;
	ps2_pkg::ps2_byte_t frame_byte;
	logic               parity_ok;

	////////////////////////////////////////////////////////////////////////////
	// Datapath and control
	////////////////////////////////////////////////////////////////////////////

	ps2_line_sync #(
		.sync_stages(sync_stages)
	) line_sync0 (
		.clk(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
		.fall_strobe(fall_strobe), .data_bit(data_bit)
	);

	ps2_bit_timer #(
		.timeout_cycles(timeout_cycles)
	) bit_timer0 (
		.clk(clk), .reset(reset), .frame_clear(frame_clear), .shift_en(shift_en),
		.fall_strobe(fall_strobe), .timing_active(timing_active),
		.last_data_bit(last_data_bit), .timeout(timeout)
	);

	ps2_rx_fsm rx_fsm0 (
		.clk(clk), .reset(reset), .rx_enable(rx_enable), .hold_data(hold_data),
		.fall_strobe(fall_strobe), .data_bit(data_bit), .last_data_bit(last_data_bit),
		.timeout(timeout), .parity_ok(parity_ok), .frame_clear(frame_clear),
		.shift_en(shift_en), .timing_active(timing_active), .load_byte(load_byte),
		.load_error(load_error), .err_sel(err_sel), .rx_complete(rx_complete)
	);

	ps2_frame_shift frame_shift0 (
		.clk(clk), .reset(reset), .frame_clear(frame_clear), .shift_en(shift_en),
		.data_bit(data_bit), .frame_byte(frame_byte), .parity_ok(parity_ok)
	);

	ps2_code_hold code_hold0 (
		.clk(clk), .reset(reset), .load_byte(load_byte), .load_error(load_error),
		.frame_byte(frame_byte), .err_sel(err_sel), .rx_data(rx_data),
		.rx_error(rx_error), .err_code(err_code)
	);

endmodule

// File: tb/ps2_rx_tb.sv
`timescale 1ns/1ps

module ps2_rx_tb;

	// PS/2 half period in clk cycles
	localparam int half_period = 20;
	// Idle line between frames
	localparam int frame_gap = 40;
	// 24 frames of 11 bits at 40 cycles each, plus the stall, with margin
	localparam int max_cycles = 40000;

	logic               clk = 1'b0;
	logic               reset;
	logic               rx_enable;
	logic               ps2_clk;
	logic               ps2_data;
	logic               hold_data;
	ps2_pkg::ps2_byte_t rx_data;
	logic               rx_complete;
	logic               rx_error;
	ps2_pkg::ps2_err_t  err_code;

	// Expected DUT state
	ps2_pkg::ps2_byte_t exp_byte = '0;
	ps2_pkg::ps2_err_t  exp_code = ps2_pkg::err_none;
	logic               rx_expected = 1'b0;
	string              test_name = "reset";
	// Observed and expected event tallies
	int   complete_events = 0;
	int   error_events = 0;
	int   good_frames = 0;
	int   bad_frames = 0;
	logic complete_prev = 1'b0;
	int   cycle_count = 0;
	logic [31:0] lfsr = 32'd70344;

	ps2_rx_top #(
		.timeout_cycles(300),
		.sync_stages(2)
	) dut0 (
		.clk(clk), .reset(reset), .rx_enable(rx_enable), .ps2_clk(ps2_clk),
		.ps2_data(ps2_data), .hold_data(hold_data), .rx_data(rx_data),
		.rx_complete(rx_complete), .rx_error(rx_error), .err_code(err_code)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Checks on the DUT ports
	////////////////////////////////////////////////////////////////////////////

	// Byte on the bus while complete
	assert property (@(posedge clk) disable iff (!reset) rx_complete |-> rx_data == exp_byte)
		else report_mismatch("rx_data", int'($sampled(exp_byte)), int'($sampled(rx_data)));

	// Error code in the pulse cycle
	assert property (@(posedge clk) disable iff (!reset) rx_error |-> err_code == exp_code)
		else report_mismatch("err_code", int'($sampled(exp_code)), int'($sampled(err_code)));

	// Released byte drops one cycle later
	assert property (@(posedge clk) disable iff (!reset)
		$past(rx_complete && !hold_data) |-> !rx_complete)
		else report_mismatch("rx_complete after release", 0, 1);

	// No byte from a bad, dropped or ignored frame
	assert property (@(posedge clk) disable iff (!reset) $rose(rx_complete) |-> rx_expected)
		else report_mismatch("unexpected rx_complete", 0, 1);

	// Event counters, pre-edge values
	always @(posedge clk) begin
		if (reset) begin
			if (rx_error) begin
				error_events = error_events + 1;
			end
			if (rx_complete && !complete_prev) begin
				complete_events = complete_events + 1;
			end
		end
		complete_prev = rx_complete;
	end

	// Run limit
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout: no result after %0d clock cycles in test %s", max_cycles,
				test_name);
			fail_stop();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_stop();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("ERROR %s %s: expected %0h actual %0h", test_name, what, expected, actual);
		fail_stop();
	endtask

	// Drive point, 1 ns past the edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit
	task automatic random_byte(output ps2_pkg::ps2_byte_t value);
		for (int i = 0; i < ps2_pkg::data_bits; i++) begin
			lfsr = lfsr_next(lfsr);
			value = {lfsr[0], value[ps2_pkg::data_bits-1:1]};
		end
	endtask

	// Device model, data set while ps2_clk is high, host samples at the fall
	task automatic drive_frame(input ps2_pkg::ps2_byte_t value, input logic bad_parity,
		input logic bad_stop, input int bit_count);
		logic [10:0] frame;
		// Stop, odd parity, data LSB first, start
		frame = {~bad_stop, (~^value) ^ bad_parity, value, 1'b0};
		for (int i = 0; i < bit_count; i++) begin
			ps2_data = frame[i];
			wait_cycles(half_period);
			ps2_clk = 1'b0;
			wait_cycles(half_period);
			ps2_clk = 1'b1;
		end
		wait_cycles(half_period);
		ps2_data = 1'b1;
	endtask

	task automatic receive_good(input ps2_pkg::ps2_byte_t value);
		int target;
		exp_byte = value;
		exp_code = ps2_pkg::err_none;
		rx_expected = 1'b1;
		target = complete_events + 1;
		good_frames = good_frames + 1;
		drive_frame(value, 1'b0, 1'b0, 11);
		while (complete_events < target) begin
			wait_cycles(1);
		end
		rx_expected = 1'b0;
		wait_cycles(frame_gap);
	endtask

	// Bad frame, rx_data must keep the last good byte
	task automatic receive_error(input ps2_pkg::ps2_err_t code, input logic bad_parity,
		input logic bad_stop, input int bit_count);
		ps2_pkg::ps2_byte_t value;
		int target;
		random_byte(value);
		exp_code = code;
		target = error_events + 1;
		bad_frames = bad_frames + 1;
		drive_frame(value, bad_parity, bad_stop, bit_count);
		while (error_events < target) begin
			wait_cycles(1);
		end
		assert (rx_data == exp_byte)
			else report_mismatch("rx_data kept", int'(exp_byte), int'(rx_data));
		exp_code = ps2_pkg::err_none;
		wait_cycles(frame_gap);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		ps2_pkg::ps2_byte_t value;
		ps2_pkg::ps2_byte_t first;
		int seen_complete;
		int seen_error;
		reset = 1'b0;
		rx_enable = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		hold_data = 1'b0;
		wait_cycles(3);
		reset = 1'b1;
		wait_cycles(frame_gap);

		test_name = "good_frames";
		repeat (16) begin
			random_byte(value);
			receive_good(value);
		end

		test_name = "parity_error";
		receive_error(ps2_pkg::err_parity, 1'b1, 1'b0, 11);

		test_name = "framing_error";
		receive_error(ps2_pkg::err_frame, 1'b0, 1'b1, 11);

		// Start plus four data bits, then the device goes quiet
		test_name = "timeout";
		receive_error(ps2_pkg::err_timeout, 1'b0, 1'b0, 5);
		random_byte(value);
		receive_good(value);

		test_name = "hold";
		hold_data = 1'b1;
		random_byte(first);
		receive_good(first);
		// Second frame lands on a held byte and is lost
		random_byte(value);
		drive_frame(value, 1'b0, 1'b0, 11);
		assert (rx_complete)
			else report_mismatch("rx_complete held", 1, 0);
		hold_data = 1'b0;
		wait_cycles(2);
		assert (!rx_complete)
			else report_mismatch("rx_complete released", 0, 1);
		assert (rx_data == first)
			else report_mismatch("rx_data held", int'(first), int'(rx_data));
		wait_cycles(frame_gap);

		test_name = "enable";
		rx_enable = 1'b0;
		seen_complete = complete_events;
		seen_error = error_events;
		random_byte(value);
		drive_frame(value, 1'b0, 1'b0, 11);
		wait_cycles(frame_gap);
		assert (complete_events == seen_complete && error_events == seen_error)
			else report_mismatch("events while disabled", 0,
				complete_events + error_events - seen_complete - seen_error);
		rx_enable = 1'b1;
		wait_cycles(2);
		random_byte(value);
		receive_good(value);

		// Final tallies
		test_name = "totals";
		assert (complete_events == good_frames)
			else report_mismatch("rx_complete events", good_frames, complete_events);
		assert (error_events == bad_frames)
			else report_mismatch("rx_error events", bad_frames, error_events);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: files.f
logic/ps2_pkg.sv
logic/ps2_line_sync.sv
logic/ps2_bit_timer.sv
logic/ps2_rx_fsm.sv
logic/ps2_frame_shift.sv
logic/ps2_code_hold.sv
logic/ps2_rx_top.sv
tb/ps2_rx_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the PS/2 receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module ps2_rx_tb -f files.f -o ps2_rx_sim

# The log decides the result
./obj_dir/ps2_rx_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi
exit 1
